/* Makefile */
# Verilator flow for the cache testbench

VERILATOR ?= verilator
TOP       ?= cacheTb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
PASS_TEXT ?= Simulation completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

# the log decides pass or fail, not the exit code of the run
sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* cacheArray.sv */
// lookup is combinational, updates land on the strobe edge, reset clears valid and dirty only
`timescale 1ns/1ns
`default_nettype none

module cacheArray (
    input  wire logic                         clk,
    input  wire logic                         rst,
    // line select and compare fields
    input  wire logic [cachePkg::indexBits-1:0]  index,
    input  wire logic [cachePkg::tagBits-1:0]    tag,
    input  wire logic [cachePkg::offsetBits-1:0] offset,
    // single word store on a hit
    input  wire logic                         wordWrite,
    input  wire logic [cachePkg::wordBits-1:0]   wordData,
    // full line fill from memory
    input  wire logic                         lineLoad,
    input  wire logic [cachePkg::lineBits-1:0]   lineData,
    // lookup result for the selected line
    output cachePkg::lookupT                  result
);

    // storage, one row per line
    logic [cachePkg::wordBits-1:0] dataArray [cachePkg::numLines][cachePkg::lineWords];
    logic [cachePkg::tagBits-1:0]  tagArray [cachePkg::numLines];
    logic [cachePkg::numLines-1:0] validArray;
    logic [cachePkg::numLines-1:0] dirtyArray;

    // qualified word store
    logic doWrite;

    // only a matching resident line may take a word write
    assign doWrite = wordWrite & result.hit;

    // combinational lookup of the indexed line
    always_comb begin
        result.hit = validArray[index] && (tagArray[index] == tag);
        // a clean or empty victim needs no writeback
        result.victimDirty = validArray[index] & dirtyArray[index];
        result.victimTag = tagArray[index];
        result.word = dataArray[index][offset];
        // word 0 sits in the low bits of the packed line
        for (int w = 0; w < cachePkg::lineWords; w++) begin
            result.line[w*cachePkg::wordBits +: cachePkg::wordBits] = dataArray[index][w];
        end
    end

    // valid and dirty bookkeeping
    always_ff @(posedge clk) begin
        if (rst) begin
            validArray <= '0;
            dirtyArray <= '0;
        end else if (lineLoad) begin
            // fresh line from memory is clean
            validArray[index] <= 1'b1;
            dirtyArray[index] <= 1'b0;
        end else if (doWrite) begin
            dirtyArray[index] <= 1'b1;
        end
    end

    // tag store, written only on a fill
    always_ff @(posedge clk) begin
        if (lineLoad) begin
            tagArray[index] <= tag;
        end
    end

    // data store
    always_ff @(posedge clk) begin
        if (lineLoad) begin
            // unpack the incoming line word by word
            for (int w = 0; w < cachePkg::lineWords; w++) begin
                dataArray[index][w] <= lineData[w*cachePkg::wordBits +: cachePkg::wordBits];
            end
        end else if (doWrite) begin
            dataArray[index][offset] <= wordData;
        end
    end

endmodule

`default_nettype wire

/* cacheCtrl.sv */
// one processor access at a time, one memory transaction at a time, writeback before refill
`timescale 1ns/1ns
`default_nettype none

module cacheCtrl (
    input  wire logic                         clk,
    input  wire logic                         rst,
    // processor side, four-phase
    input  wire logic                         cpuReq,
    input  cachePkg::cpuReqT                  cpuCmd,
    output logic                              cpuAck,
    output logic [cachePkg::wordBits-1:0]     cpuRdata,
    // memory side, four-phase
    output logic                              memReq,
    output cachePkg::memReqT                  memCmd,
    input  wire logic                         memAck,
    input  wire logic [cachePkg::lineBits-1:0]   memRdata,
    // array control
    output logic [cachePkg::indexBits-1:0]    index,
    output logic [cachePkg::tagBits-1:0]      tag,
    output logic [cachePkg::offsetBits-1:0]   offset,
    output logic                              wordWrite,
    output logic [cachePkg::wordBits-1:0]     wordData,
    output logic                              lineLoad,
    output logic [cachePkg::lineBits-1:0]     lineData,
    input  cachePkg::lookupT                  result
);

    cachePkg::ctrlState state;

    // accepted processor command, held for the whole access
    cachePkg::cpuReqT cmdReg;

    // refill line captured while memory ack is high
    logic [cachePkg::lineBits-1:0] lineBuf;

    // address fields of the held command
    assign tag = cmdReg.addr[cachePkg::wordBits-1 -: cachePkg::tagBits];
    assign index = cmdReg.addr[cachePkg::wordBits-cachePkg::tagBits-1 -: cachePkg::indexBits];
    assign offset = cmdReg.addr[cachePkg::wordBits-cachePkg::tagBits-cachePkg::indexBits-1
                                -: cachePkg::offsetBits];

    // write hit merges in lookup, also after a refill
    assign wordWrite = (state == cachePkg::lookup) && result.hit && cmdReg.write;
    assign wordData = cmdReg.wdata;

    // fill once memory has finished its handshake
    assign lineLoad = (state == cachePkg::refill) && !memReq && !memAck;
    assign lineData = lineBuf;

    // main FSM
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= cachePkg::idle;
            cpuAck <= 1'b0;
            memReq <= 1'b0;
        end else begin
            unique case (state)
                cachePkg::idle: begin
                    // latch the command on the first sampled req
                    if (cpuReq) begin
                        cmdReg <= cpuCmd;
                        state <= cachePkg::lookup;
                    end
                end

                cachePkg::lookup: begin
                    if (result.hit) begin
                        // read data, don't care after a write
                        cpuRdata <= result.word;
                        cpuAck <= 1'b1;
                        state <= cachePkg::respond;
                    end else if (result.victimDirty) begin
                        // evict the resident line first
                        memReq <= 1'b1;
                        memCmd.write <= 1'b1;
                        memCmd.lineAddr <= {result.victimTag, index};
                        memCmd.data <= result.line;
                        state <= cachePkg::writeBack;
                    end else begin
                        // clean or empty victim, fetch straight away
                        memReq <= 1'b1;
                        memCmd.write <= 1'b0;
                        memCmd.lineAddr <= {tag, index};
                        memCmd.data <= '0;
                        state <= cachePkg::refill;
                    end
                end

                cachePkg::writeBack: begin
                    if (memReq && memAck) begin
                        // write accepted, release req
                        memReq <= 1'b0;
                    end else if (!memReq && !memAck) begin
                        // handshake closed, start the refill
                        memReq <= 1'b1;
                        memCmd.write <= 1'b0;
                        memCmd.lineAddr <= {tag, index};
                        memCmd.data <= '0;
                        state <= cachePkg::refill;
                    end
                end

                cachePkg::refill: begin
                    if (memReq && memAck) begin
                        // line valid while ack is high
                        lineBuf <= memRdata;
                        memReq <= 1'b0;
                    end else if (!memReq && !memAck) begin
                        // lineLoad strobes this cycle, rerun the lookup
                        state <= cachePkg::lookup;
                    end
                end

                cachePkg::respond: begin
                    // hold ack until the processor drops req
                    if (!cpuReq) begin
                        cpuAck <= 1'b0;
                        state <= cachePkg::idle;
                    end
                end

                default: begin
                    state <= cachePkg::idle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* cachePkg.sv */
// sizes are fixed here, addresses are word aligned and the two byte bits are ignored
`default_nettype none

package cachePkg;

    // word and address width
    localparam int wordBits = 32;
    // words per line
    localparam int lineWords = 4;
    // lines in the direct-mapped cache
    localparam int numLines = 16;

    // address split, tag | index | offset | byte
    localparam int offsetBits = 2;
    localparam int indexBits = 4;
    localparam int tagBits = 24;

    // full line as it travels to and from memory
    localparam int lineBits = 128;

    // miss-handling controller states
    typedef enum logic [2:0] {
        idle,
        lookup,
        writeBack,
        refill,
        respond
    } ctrlState;

    // processor request, 65 bits
    typedef struct packed {
        logic                write;
        logic [wordBits-1:0] addr;
        logic [wordBits-1:0] wdata;
    } cpuReqT;

    // memory request on line granularity, 157 bits
    typedef struct packed {
        logic                          write;
        logic [tagBits+indexBits-1:0] lineAddr;
        logic [lineBits-1:0]          data;
    } memReqT;

    // array lookup as seen by the controller
    typedef struct packed {
        logic                hit;
        logic                victimDirty;
        logic [tagBits-1:0]  victimTag;
        logic [wordBits-1:0] word;
        logic [lineBits-1:0] line;
    } lookupT;

endpackage

`default_nettype wire

/* cacheTb.sv */
// word-aligned accesses only, stops at the first mismatch, random part uses a 64-word window
`timescale 1ns/1ns
`default_nettype none

module cacheTb;

    // about 400 accesses at a worst case near 30 cycles each
    localparam int maxCycles = 12000;
    localparam int randomAccesses = 400;
    localparam logic [31:0] fillKey = 32'h5a3c_96e1;

    logic clk;
    logic rst;
    logic cpuReq;
    cachePkg::cpuReqT cpuCmd;
    logic cpuAck;
    logic [cachePkg::wordBits-1:0] cpuRdata;
    logic memReq;
    cachePkg::memReqT memCmd;
    logic memAck;
    logic [cachePkg::lineBits-1:0] memRdata;

    integer seed;
    int cycles = 0;
    int errorCount = 0;
    int memReads = 0;
    int memWrites = 0;
    logic [27:0] lastWriteAddr;
    logic prevCpuAck;
    logic prevMemReq;
    // word shadow keyed by byte address
    logic [31:0] shadow [logic [31:0]];

    tbClock clockGen (.clk(clk), .rst(rst));

    tbMemory memModel (
        .clk(clk), .rst(rst), .memReq(memReq), .memCmd(memCmd),
        .fillKey(fillKey), .memAck(memAck), .memRdata(memRdata)
    );

    cacheTop cacheTop_inst (
        .clk(clk), .rst(rst), .cpuReq(cpuReq), .cpuCmd(cpuCmd), .cpuAck(cpuAck),
        .cpuRdata(cpuRdata), .memReq(memReq), .memCmd(memCmd), .memAck(memAck),
        .memRdata(memRdata)
    );

    // last written value, else the memory fill pattern
    function automatic logic [31:0] expectedWord(input logic [31:0] addr);
        if (shadow.exists(addr)) begin
            return shadow[addr];
        end
        return addr ^ fillKey;
    endfunction

    function automatic logic [127:0] expectedLine(input logic [27:0] lineAddr);
        logic [127:0] line;
        for (int w = 0; w < 4; w++) begin
            line[w*32 +: 32] = expectedWord({lineAddr, w[1:0], 2'b00});
        end
        return line;
    endfunction

    task automatic checkValue(input logic [127:0] actual, input logic [127:0] expected,
                              input string what);
        if (actual !== expected) begin
            errorCount++;
            $display("FAIL at %0t ns: %s, got %0h, expected %0h", $time, what, actual, expected);
            $display("Simulation failed");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    // memory traffic since the given counts
    task automatic checkTraffic(input int readsBefore, input int writesBefore,
                                input int reads, input int writes, input string what);
        checkValue(128'(memReads - readsBefore), 128'(reads), {what, " memory reads"});
        checkValue(128'(memWrites - writesBefore), 128'(writes), {what, " memory writes"});
    endtask

    // one complete four-phase exchange
    task automatic access(input logic isWrite, input logic [31:0] addr, input logic [31:0] data);
        @(posedge clk);
        #1;
        cpuCmd.write = isWrite;
        cpuCmd.addr = addr;
        cpuCmd.wdata = data;
        cpuReq = 1'b1;
        do @(posedge clk); while (!cpuAck);
        #1 cpuReq = 1'b0;
        if (isWrite) begin
            shadow[addr] = data;
        end
        do @(posedge clk); while (cpuAck);
    endtask

    // read data checked on the first edge that sees ack
    always @(posedge clk) begin
        if (rst) begin
            prevCpuAck <= 1'b0;
        end else begin
            if (cpuAck && !prevCpuAck && !cpuCmd.write) begin
                checkValue(128'(cpuRdata), 128'(expectedWord(cpuCmd.addr)), "read data");
            end
            prevCpuAck <= cpuAck;
        end
    end

    // count memory requests, written lines must match the shadow
    always @(posedge clk) begin
        if (rst) begin
            prevMemReq <= 1'b0;
        end else begin
            if (memReq && !prevMemReq) begin
                if (memCmd.write) begin
                    memWrites++;
                    lastWriteAddr = memCmd.lineAddr;
                    checkValue(memCmd.data, expectedLine(memCmd.lineAddr), "written line");
                end else begin
                    memReads++;
                end
            end
            prevMemReq <= memReq;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= maxCycles) begin
            $display("timeout, the run did not finish within %0d cycles", maxCycles);
            $display("Simulation failed");
            $fatal(1, "timeout");
        end
    end

    initial begin : stimulus
        int reads0;
        int writes0;
        logic [31:0] r;
        logic [31:0] addr;
        seed = 32'h9789_95e3;
        cpuReq = 1'b0;
        cpuCmd = '0;
        lastWriteAddr = '0;
        do @(posedge clk); while (rst);

        // cold read refills, second read of the line hits
        reads0 = memReads;
        writes0 = memWrites;
        access(1'b0, 32'h0000_1040, '0);
        checkTraffic(reads0, writes0, 1, 0, "cold read");
        access(1'b0, 32'h0000_104c, '0);
        checkTraffic(reads0, writes0, 1, 0, "same line read");

        // write then read back, nothing written to memory
        writes0 = memWrites;
        access(1'b1, 32'h0000_2058, 32'hdead_beef);
        access(1'b0, 32'h0000_2058, '0);
        checkValue(128'(memWrites - writes0), 128'(0), "write then read memory writes");

        // dirty A evicted by B on index 6, then A comes back through a refill
        access(1'b1, 32'h0000_3064, 32'h1234_5678);
        reads0 = memReads;
        writes0 = memWrites;
        access(1'b0, 32'h0000_7064, '0);
        checkTraffic(reads0, writes0, 1, 1, "dirty eviction");
        checkValue(128'(lastWriteAddr), 128'(28'h000_0306), "writeback line address");
        access(1'b0, 32'h0000_3064, '0);
        checkTraffic(reads0, writes0, 2, 1, "reload after eviction");

        // clean conflicts on index 7
        writes0 = memWrites;
        access(1'b0, 32'h0000_4070, '0);
        access(1'b0, 32'h0000_5070, '0);
        access(1'b0, 32'h0000_4070, '0);
        checkValue(128'(memWrites - writes0), 128'(0), "clean eviction memory writes");

        // 4 tags x 4 indexes x 4 offsets keeps conflicts frequent
        for (int i = 0; i < randomAccesses; i++) begin
            r = $random(seed);
            addr = 32'h0001_0000 | (r & 32'h0000_033c);
            access(r[16], addr, $random(seed));
        end

        if (errorCount == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* cacheTop.sv */
// wrapper only, the controller owns both handshakes and the array holds the lines
`timescale 1ns/1ns
`default_nettype none

module cacheTop (
    input  wire logic                         clk,
    input  wire logic                         rst,
    // processor port
    input  wire logic                         cpuReq,
    input  cachePkg::cpuReqT                  cpuCmd,
    output logic                              cpuAck,
    output logic [cachePkg::wordBits-1:0]     cpuRdata,
    // memory port
    output logic                              memReq,
    output cachePkg::memReqT                  memCmd,
    input  wire logic                         memAck,
    input  wire logic [cachePkg::lineBits-1:0]   memRdata
);

    // controller to array
    logic [cachePkg::indexBits-1:0]  index;
    logic [cachePkg::tagBits-1:0]    tag;
    logic [cachePkg::offsetBits-1:0] offset;
    logic                            wordWrite;
    logic [cachePkg::wordBits-1:0]   wordData;
    logic                            lineLoad;
    logic [cachePkg::lineBits-1:0]   lineData;
    // array to controller
    cachePkg::lookupT                result;

    cacheCtrl cacheCtrl_inst (
        .clk       (clk),
        .rst       (rst),
        .cpuReq    (cpuReq),
        .cpuCmd    (cpuCmd),
        .cpuAck    (cpuAck),
        .cpuRdata  (cpuRdata),
        .memReq    (memReq),
        .memCmd    (memCmd),
        .memAck    (memAck),
        .memRdata  (memRdata),
        .index     (index),
        .tag       (tag),
        .offset    (offset),
        .wordWrite (wordWrite),
        .wordData  (wordData),
        .lineLoad  (lineLoad),
        .lineData  (lineData),
        .result    (result)
    );

    cacheArray cacheArray_inst (
        .clk       (clk),
        .rst       (rst),
        .index     (index),
        .tag       (tag),
        .offset    (offset),
        .wordWrite (wordWrite),
        .wordData  (wordData),
        .lineLoad  (lineLoad),
        .lineData  (lineData),
        .result    (result)
    );

endmodule

`default_nettype wire

/* cacheTop_asserts.sv */
// sampled on the rising clock, handshake checks are off while rst is high
`timescale 1ns/1ns
`default_nettype none

module cacheTopAsserts (
    input wire logic               clk,
    input wire logic               rst,
    input wire logic               cpuReq,
    input wire logic               cpuAck,
    input wire logic               memReq,
    input wire cachePkg::memReqT   memCmd,
    input wire cachePkg::ctrlState state
);

    // a reset edge leaves both handshake outputs low
    resetQuiet: assert property (@(posedge clk) rst |=> (!cpuAck && !memReq))
        else $error("cpuAck or memReq high after a reset cycle");

    // command held while the memory request is open
    memCmdStable: assert property (@(posedge clk) disable iff (rst)
        (memReq && $past(memReq)) |-> $stable(memCmd))
        else $error("memCmd changed while memReq was high");

    ackNeedsReq: assert property (@(posedge clk) disable iff (rst)
        $rose(cpuAck) |-> cpuReq)
        else $error("cpuAck rose without cpuReq");

    // idle takes the request, no memory request two edges later means a hit
    // so ack must be seen on that same edge
    hitLatency: assert property (@(posedge clk) disable iff (rst)
        (state == cachePkg::idle && cpuReq) ##2 !memReq
        |-> $rose(cpuAck))
        else $error("hit did not answer in 2 cycles");

endmodule

bind cacheTop cacheTopAsserts cacheTopAsserts_inst (
    .clk    (clk),
    .rst    (rst),
    .cpuReq (cpuReq),
    .cpuAck (cpuAck),
    .memReq (memReq),
    .memCmd (memCmd),
    .state  (cacheCtrl_inst.state)
);

`default_nettype wire

/* files.f */
cachePkg.sv
cacheArray.sv
cacheCtrl.sv
cacheTop.sv
tbClock.sv
tbMemory.sv
cacheTop_asserts.sv
cacheTb.sv

/* tbClock.sv */
// free running 10 ns clock, rst held high for the first 5 rising edges
`timescale 1ns/1ns
`default_nettype none

module tbClock (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // release 1 ns after the fifth edge, like all other stimulus
    initial begin
        rst = 1'b1;
        repeat (5) @(posedge clk);
        #1 rst = 1'b0;
    end

endmodule

`default_nettype wire

/* tbMemory.sv */
// sparse line memory, unwritten words read as byte address XOR fillKey, ack after 1 to 3 cycles
`timescale 1ns/1ns
`default_nettype none

module tbMemory (
    input  wire logic                            clk,
    input  wire logic                            rst,
    input  wire logic                            memReq,
    input  wire cachePkg::memReqT                memCmd,
    input  wire logic [cachePkg::wordBits-1:0]   fillKey,
    output logic                                 memAck,
    output logic [cachePkg::lineBits-1:0]        memRdata
);

    // only lines that were written back are stored
    logic [cachePkg::lineBits-1:0] lines [logic [cachePkg::tagBits+cachePkg::indexBits-1:0]];
    integer seed;
    int delay;

    // stored line, or else the fill pattern word by word
    function automatic logic [cachePkg::lineBits-1:0] readLine(
        input logic [cachePkg::tagBits+cachePkg::indexBits-1:0] lineAddr
    );
        logic [cachePkg::lineBits-1:0] line;
        if (lines.exists(lineAddr)) begin
            return lines[lineAddr];
        end
        // word 0 in the low bits, as the cache packs it
        for (int w = 0; w < cachePkg::lineWords; w++) begin
            line[w*cachePkg::wordBits +: cachePkg::wordBits] = {lineAddr, w[1:0], 2'b00} ^ fillKey;
        end
        return line;
    endfunction

    initial begin
        seed = 32'h9789_95e3;
        memAck = 1'b0;
        memRdata = '0;
        forever begin
            @(posedge clk);
            if (!rst && memReq && !memAck) begin
                // random latency of one to three cycles
                delay = 1 + ($unsigned($random(seed)) % 3);
                repeat (delay - 1) @(posedge clk);
                #1;
                if (memCmd.write) begin
                    lines[memCmd.lineAddr] = memCmd.data;
                end else begin
                    memRdata = readLine(memCmd.lineAddr);
                end
                memAck = 1'b1;
                // hold ack and data until req drops
                do @(posedge clk); while (memReq);
                #1 memAck = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire
